/* hdl/stm_pkg.sv */
package stm_pkg;

  localparam int num_segment = 2;
  localparam logic [31:0] rep_infinite = 32'hffff_ffff;

  // transition modes.
  localparam logic [7:0] tm_sync_idx = 8'd1;
  localparam logic [7:0] tm_sys_time = 8'd2;
  localparam logic [7:0] tm_gpio = 8'd3;
  localparam logic [7:0] tm_ext = 8'd240;

  typedef struct packed {
    logic psel;
    logic penable;
    logic pwrite;
    logic [15:0] paddr;
    logic [31:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic pready;
    logic pslverr;
  } apb_rsp_t;

  typedef struct packed {
    logic [61:0] pad;
    logic [1:0] gpio_sel;
  } gpio_value_t;

  // one word, read as a target time or as a gpio select.
  typedef union packed {
    logic [63:0] target_time;
    gpio_value_t gpio;
  } trans_value_u;

  typedef struct packed {
    logic req_segment;
    logic [7:0] mode;
    trans_value_u value;
    logic [num_segment-1:0][15:0] cycle;
    logic [num_segment-1:0][31:0] rep;
  } stm_settings_t;

  localparam logic [15:0] reg_ctrl = 16'h0000;
  localparam logic [15:0] reg_value_lo = 16'h0004;
  localparam logic [15:0] reg_value_hi = 16'h0008;
  localparam logic [15:0] reg_cycle0 = 16'h0010;
  localparam logic [15:0] reg_cycle1 = 16'h0014;
  localparam logic [15:0] reg_rep0 = 16'h0018;
  localparam logic [15:0] reg_rep1 = 16'h001c;
  localparam logic [15:0] reg_status = 16'h0020;
  localparam logic [15:0] pat_base = 16'h1000;

endpackage

/* hdl/stm_apb_regs.sv */
`timescale 1ns/1ps
module stm_apb_regs import stm_pkg::*; #(
  parameter int pattern_depth = 64
) (
  input logic CLK,
  input logic reset,
  input apb_req_t apb_req,
  output apb_rsp_t apb_rsp,
  output stm_settings_t settings,
  output logic update,
  input logic segment,
  input logic stop,
  output logic pat_we,
  output logic [$clog2(pattern_depth):0] pat_addr,
  output logic [31:0] pat_data
);

  localparam int pat_span = 4 * num_segment * pattern_depth;

  stm_settings_t settings_q;
  logic setup;
  logic access;
  logic wr;
  logic in_pat;
  logic mapped;
  logic [31:0] rd_data;
  logic [31:0] prdata_q;
  logic pready_q;
  logic pslverr_q;

  assign setup = apb_req.psel & ~apb_req.penable;
  assign access = apb_req.psel & apb_req.penable;
  assign wr = access & apb_req.pwrite;
  assign in_pat = (int'(apb_req.paddr) >= int'(pat_base)) &&
                  (int'(apb_req.paddr) < int'(pat_base) + pat_span);

  always_comb begin
    mapped = 1'b1;
    rd_data = '0;
    case (apb_req.paddr)
      reg_ctrl: rd_data = {22'd0, settings_q.mode, settings_q.req_segment, 1'b0};
      reg_value_lo: rd_data = settings_q.value.target_time[31:0];
      reg_value_hi: rd_data = settings_q.value.target_time[63:32];
      reg_cycle0: rd_data = {16'd0, settings_q.cycle[0]};
      reg_cycle1: rd_data = {16'd0, settings_q.cycle[1]};
      reg_rep0: rd_data = settings_q.rep[0];
      reg_rep1: rd_data = settings_q.rep[1];
      reg_status: rd_data = {30'd0, stop, segment};
      default: mapped = in_pat; // pattern words are write only.
    endcase
  end

  always_ff @(posedge CLK) begin
    if (reset) begin
      settings_q <= '0;
      update <= 1'b0;
    end else begin
      update <= wr && (apb_req.paddr == reg_ctrl) && apb_req.pwdata[0];
      if (wr) begin
        case (apb_req.paddr)
          reg_ctrl: begin
            settings_q.req_segment <= apb_req.pwdata[1];
            settings_q.mode <= apb_req.pwdata[9:2];
          end
          reg_value_lo: settings_q.value.target_time[31:0] <= apb_req.pwdata;
          reg_value_hi: settings_q.value.target_time[63:32] <= apb_req.pwdata;
          reg_cycle0: settings_q.cycle[0] <= apb_req.pwdata[15:0];
          reg_cycle1: settings_q.cycle[1] <= apb_req.pwdata[15:0];
          reg_rep0: settings_q.rep[0] <= apb_req.pwdata;
          reg_rep1: settings_q.rep[1] <= apb_req.pwdata;
          default: ;
        endcase
      end
    end
  end

  // response for the access phase, prepared during setup.
  always_ff @(posedge CLK) begin
    if (reset) begin
      pready_q <= 1'b0;
      pslverr_q <= 1'b0;
    end else begin
      pready_q <= setup;
      pslverr_q <= setup & ~mapped;
    end
  end

  always_ff @(posedge CLK) begin
    if (setup) begin
      prdata_q <= rd_data;
    end
  end

  assign apb_rsp = {prdata_q, pready_q, pslverr_q};
  assign settings = settings_q;

  assign pat_we = wr & in_pat;
  assign pat_addr = apb_req.paddr[2 +: $clog2(pattern_depth) + 1]; // word address.
  assign pat_data = apb_req.pwdata;

endmodule

/* hdl/stm_sync_timer.sv */
`timescale 1ns/1ps
module stm_sync_timer import stm_pkg::*; (
  input logic CLK,
  input logic reset,
  input logic sync_pulse,
  input stm_settings_t settings,
  output logic [num_segment-1:0][15:0] sync_idx
);

  logic [num_segment-1:0][15:0] idx_next;

  // wrap at the cycle value, also when cycle was shortened.
  always_comb begin
    for (int i = 0; i < num_segment; i++) begin
      if (sync_idx[i] >= settings.cycle[i]) begin
        idx_next[i] = '0;
      end else begin
        idx_next[i] = sync_idx[i] + 16'd1;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (reset) begin
      sync_idx <= '0;
    end else if (sync_pulse) begin
      sync_idx <= idx_next; // all segments step together.
    end
  end

endmodule

/* hdl/stm_swapchain.sv */
`timescale 1ns/1ps
module stm_swapchain import stm_pkg::*; (
  input logic CLK,
  input logic reset,
  input logic [63:0] sys_time,
  input logic update,
  input stm_settings_t settings,
  input logic [num_segment-1:0][15:0] sync_idx,
  input logic [3:0] gpio_in,
  output logic segment,
  output logic stop,
  output logic [15:0] idx
);

  typedef enum logic [1:0] {
    wait_start,
    finite_loop,
    infinite_loop
  } state_t;

  typedef enum logic {
    idx_mode_sync,
    idx_mode_tic
  } idx_mode_t;

  state_t state;
  idx_mode_t idx_mode;
  logic ext_mode;
  logic req_segment;
  logic [31:0] rep;
  logic [31:0] loop_cnt;
  logic time_reached;
  logic [num_segment-1:0][15:0] idx_old;
  logic [num_segment-1:0][15:0] tic_idx;
  logic [num_segment-1:0] idx_changed;
  logic [num_segment-1:0] idx_wrap;
  logic tic_done;
  logic loop_step;
  logic fire;

  always_comb begin
    for (int i = 0; i < num_segment; i++) begin
      idx_changed[i] = idx_old[i] != sync_idx[i];
      idx_wrap[i] = idx_changed[i] && (sync_idx[i] == '0);
    end
  end

  assign tic_done = idx_changed[segment] && (tic_idx[segment] == settings.cycle[segment]);
  assign loop_step = (idx_mode == idx_mode_sync) ? idx_wrap[segment] : tic_done;
  assign idx = (idx_mode == idx_mode_sync) ? sync_idx[segment] : tic_idx[segment];

  // transition event for the waiting segment.
  always_comb begin
    case (settings.mode)
      tm_sync_idx: fire = idx_wrap[req_segment];
      tm_sys_time: fire = time_reached;
      tm_gpio: fire = idx_changed[req_segment] && gpio_in[settings.value.gpio.gpio_sel];
      default: fire = 1'b0;
    endcase
  end

  always_ff @(posedge CLK) begin
    if (reset) begin
      idx_old <= '0;
      time_reached <= 1'b0;
    end else begin
      idx_old <= sync_idx;
      time_reached <= sys_time >= settings.value.target_time;
    end
  end

  always_ff @(posedge CLK) begin
    if (update) begin
      rep <= settings.rep[settings.req_segment];
    end
  end

  always_ff @(posedge CLK) begin
    if (reset) begin
      state <= infinite_loop;
      idx_mode <= idx_mode_sync;
      ext_mode <= 1'b0;
      segment <= 1'b0;
      req_segment <= 1'b0;
      stop <= 1'b0;
      loop_cnt <= '0;
      tic_idx <= '0;
    end else if (update) begin
      stop <= 1'b0;
      if ((settings.req_segment == segment) ||
          (settings.rep[settings.req_segment] == rep_infinite)) begin
        segment <= settings.req_segment; // no change when already playing.
        idx_mode <= idx_mode_sync;
        ext_mode <= settings.mode == tm_ext;
        state <= infinite_loop;
      end else begin
        req_segment <= settings.req_segment;
        state <= wait_start;
      end
    end else begin
      case (state)
        wait_start: begin
          if (fire) begin
            segment <= req_segment;
            loop_cnt <= '0;
            tic_idx[req_segment] <= '0;
            idx_mode <= (settings.mode == tm_sync_idx) ? idx_mode_sync : idx_mode_tic;
            state <= finite_loop;
          end
        end
        finite_loop: begin
          if ((idx_mode == idx_mode_tic) && idx_changed[segment]) begin
            tic_idx[segment] <= tic_done ? 16'd0 : tic_idx[segment] + 16'd1;
          end
          if (loop_step) begin
            if (loop_cnt == rep) begin
              stop <= 1'b1;
            end else begin
              loop_cnt <= loop_cnt + 32'd1;
            end
          end
        end
        infinite_loop: begin
          if (ext_mode && idx_wrap[segment]) begin
            segment <= ~segment; // alternate on every wrap.
          end
        end
        default: state <= infinite_loop;
      endcase
    end
  end

endmodule

/* hdl/stm_pattern_reader.sv */
`timescale 1ns/1ps
module stm_pattern_reader import stm_pkg::*; #(
  parameter int pattern_depth = 64
) (
  input logic CLK,
  input logic reset,
  input logic pat_we,
  input logic [$clog2(pattern_depth):0] pat_addr,
  input logic [31:0] pat_data,
  input logic segment,
  input logic [15:0] idx,
  input logic stop,
  output logic [31:0] drive,
  output logic drive_valid
);

  localparam int dw = $clog2(pattern_depth);

  logic [31:0] mem [num_segment * pattern_depth];
  logic [dw:0] rd_addr;

  // segment selects the upper half.
  assign rd_addr = {segment, idx[dw-1:0]};

  always_ff @(posedge CLK) begin
    if (pat_we) begin
      mem[pat_addr] <= pat_data;
    end
  end

  always_ff @(posedge CLK) begin
    if (!stop) begin
      drive <= mem[rd_addr]; // held once stopped.
    end
  end

  always_ff @(posedge CLK) begin
    if (reset) begin
      drive_valid <= 1'b0;
    end else begin
      drive_valid <= ~stop;
    end
  end

endmodule

/* hdl/stm_top.sv */
`timescale 1ns/1ps
module stm_top import stm_pkg::*; #(
  parameter int pattern_depth = 64
) (
  input logic CLK,
  input logic reset,
  input apb_req_t apb_req,
  output apb_rsp_t apb_rsp,
  input logic [63:0] sys_time,
  input logic sync_pulse,
  input logic [3:0] gpio_in,
  output logic [31:0] drive,
  output logic drive_valid,
  output logic segment,
  output logic stop
);

  stm_settings_t settings;
  logic update;
  logic pat_we;
  logic [$clog2(pattern_depth):0] pat_addr;
  logic [31:0] pat_data;
  logic [num_segment-1:0][15:0] sync_idx;
  logic [15:0] idx;

  stm_apb_regs #(
    .pattern_depth(pattern_depth)
  ) regs0 (
    .CLK(CLK),
    .reset(reset),
    .apb_req(apb_req),
    .apb_rsp(apb_rsp),
    .settings(settings),
    .update(update),
    .segment(segment),
    .stop(stop),
    .pat_we(pat_we),
    .pat_addr(pat_addr),
    .pat_data(pat_data)
  );

  stm_sync_timer timer0 (
    .CLK(CLK),
    .reset(reset),
    .sync_pulse(sync_pulse),
    .settings(settings),
    .sync_idx(sync_idx)
  );

  stm_swapchain swap0 (
    .CLK(CLK),
    .reset(reset),
    .sys_time(sys_time),
    .update(update),
    .settings(settings),
    .sync_idx(sync_idx),
    .gpio_in(gpio_in),
    .segment(segment),
    .stop(stop),
    .idx(idx)
  );

  stm_pattern_reader #(
    .pattern_depth(pattern_depth)
  ) reader0 (
    .CLK(CLK),
    .reset(reset),
    .pat_we(pat_we),
    .pat_addr(pat_addr),
    .pat_data(pat_data),
    .segment(segment),
    .idx(idx),
    .stop(stop),
    .drive(drive),
    .drive_valid(drive_valid)
  );

endmodule

/* bench/stm_tb_sva.sv */
`timescale 1ns/1ps
module stm_tb_sva (
  input logic CLK,
  input logic reset,
  input logic psel,
  input logic penable,
  input logic pready,
  input logic update,
  input logic segment,
  input logic stop,
  input logic looping
);

  ready_in_access: assert property (@(posedge CLK) disable iff (reset)
    pready |-> psel && penable) else $error("pready outside an access phase");

  update_single: assert property (@(posedge CLK) disable iff (reset)
    update |=> !update) else $error("update longer than one cycle");

  segment_cause: assert property (@(posedge CLK) disable iff (reset)
    !$stable(segment) |-> $past(update) || $past(looping))
    else $error("segment changed without update or loop state");

  stop_release: assert property (@(posedge CLK) disable iff (reset)
    $fell(stop) |-> $past(update)) else $error("stop fell without update");

endmodule

bind stm_apb_regs stm_tb_sva regs_sva (
  .CLK(CLK), .reset(reset), .psel(apb_req.psel), .penable(apb_req.penable),
  .pready(apb_rsp.pready), .update(update), .segment(segment), .stop(stop),
  .looping(1'b1)
);

bind stm_swapchain stm_tb_sva swap_sva (
  .CLK(CLK), .reset(reset), .psel(1'b0), .penable(1'b0), .pready(1'b0),
  .update(update), .segment(segment), .stop(stop),
  .looping((state == wait_start) || ((state == infinite_loop) && ext_mode))
);

/* bench/stm_tb.sv */
`timescale 1ns/1ps
module stm_tb import stm_pkg::*; ();

  logic CLK = 1'b0;
  logic reset;
  apb_req_t apb_req;
  apb_rsp_t apb_rsp;
  logic [63:0] sys_time;
  logic sync_pulse;
  logic [3:0] gpio_in;
  logic [31:0] drive;
  logic drive_valid;
  logic segment;
  logic stop;

  logic [31:0] mem_m [2][64];
  logic [15:0] m_cycle [2];
  logic [15:0] m_idx [2];
  logic [15:0] p1 [2];
  int cyc;
  int wrap_at [2];
  int wrap_cnt [2];
  int chg_cnt [2];
  logic pulse_en;
  int gap;
  logic m_seg;

  stm_top #(.pattern_depth(64)) dut0 (
    .CLK(CLK), .reset(reset), .apb_req(apb_req), .apb_rsp(apb_rsp),
    .sys_time(sys_time), .sync_pulse(sync_pulse), .gpio_in(gpio_in),
    .drive(drive), .drive_valid(drive_valid), .segment(segment), .stop(stop)
  );

  always #2 CLK = ~CLK;

  // timer model with index history and event counts.
  always @(posedge CLK) begin
    cyc++;
    for (int s = 0; s < 2; s++) begin
      p1[s] = m_idx[s];
      if (reset) begin
        m_idx[s] = '0;
      end else if (sync_pulse) begin
        m_idx[s] = (m_idx[s] >= m_cycle[s]) ? 16'd0 : m_idx[s] + 16'd1;
        if (m_idx[s] != p1[s]) begin
          chg_cnt[s]++;
          if (m_idx[s] == 16'd0) begin
            wrap_cnt[s]++;
            wrap_at[s] = cyc;
          end
        end
      end
    end
  end

  always @(negedge CLK) begin
    if (pulse_en && gap == 0) begin
      sync_pulse = 1'b1;
      gap = 2 + int'($urandom % 4); // 3 to 6 cycles apart.
    end else begin
      sync_pulse = 1'b0;
      if (gap > 0) gap--;
    end
  end

  task automatic give_up(input string what);
    $display("timeout while waiting for %s", what);
    $display("STATUS: FAIL");
    $fatal(1, "timeout");
  endtask

  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("FAIL %s expected %h actual %h", name, exp, act);
      $display("STATUS: FAIL");
      $fatal(1, "word mismatch");
    end
  endtask

  task automatic check_segment(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("FAIL %s expected %b actual %b", name, exp, act);
      $display("STATUS: FAIL");
      $fatal(1, "segment mismatch");
    end
  endtask

  task automatic check_stop(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("FAIL %s expected %b actual %b", name, exp, act);
      $display("STATUS: FAIL");
      $fatal(1, "stop mismatch");
    end
  endtask

  task automatic wait_ready();
    int n;
    n = 0;
    while (apb_rsp.pready !== 1'b1) begin
      if (n >= 10) give_up("pready");
      @(negedge CLK);
      n++;
    end
  endtask

  task automatic apb_write(input logic [15:0] addr, input logic [31:0] data);
    pulse_en = 1'b0; // keep sync pulses clear of the transfer.
    repeat (2) @(negedge CLK);
    apb_req.psel = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite = 1'b1;
    apb_req.paddr = addr;
    apb_req.pwdata = data;
    @(negedge CLK);
    apb_req.penable = 1'b1;
    wait_ready();
    @(negedge CLK);
    apb_req = '0;
    pulse_en = 1'b1;
  endtask

  task automatic apb_read(input logic [15:0] addr, output logic [31:0] data, output logic err);
    @(negedge CLK);
    apb_req.psel = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite = 1'b0;
    apb_req.paddr = addr;
    @(negedge CLK);
    apb_req.penable = 1'b1;
    wait_ready();
    data = apb_rsp.prdata;
    err = apb_rsp.pslverr;
    @(negedge CLK);
    apb_req = '0;
  endtask

  task automatic write_ctrl(input logic req, input logic [7:0] mode);
    apb_write(reg_ctrl, {22'd0, mode, req, 1'b1});
  endtask

  task automatic wait_segment(input logic exp, input int limit);
    int n;
    n = 0;
    while (segment !== exp) begin
      if (n >= limit) give_up("segment change");
      @(negedge CLK);
      n++;
    end
  endtask

  task automatic wait_stop(input int limit);
    int n;
    n = 0;
    while (stop !== 1'b1) begin
      if (n >= limit) give_up("stop");
      @(negedge CLK);
      n++;
    end
  endtask

  task automatic hold_segment(input int s, input int count, input logic exp);
    int base;
    int n;
    base = chg_cnt[s];
    n = 0;
    while (chg_cnt[s] < base + count) begin
      if (n >= 1000) give_up("index changes");
      @(negedge CLK);
      check_segment("hold before transition", exp, segment);
      n++;
    end
  endtask

  initial begin
    logic [15:0] addrs [6];
    logic [31:0] v;
    logic [31:0] rd;
    logic err;
    int r;
    int base;
    logic [1:0] sel;
    logic [63:0] target;
    addrs = '{reg_value_lo, reg_value_hi, reg_cycle0, reg_cycle1, reg_rep0, reg_rep1};
    void'($urandom(32'ha769));
    reset = 1'b1;
    apb_req = '0;
    sys_time = '0;
    sync_pulse = 1'b0;
    gpio_in = '0;
    pulse_en = 1'b0;
    gap = 0;
    cyc = 0;
    m_seg = 1'b0;
    for (int s = 0; s < 2; s++) begin
      m_cycle[s] = '0;
      m_idx[s] = '0;
      p1[s] = '0;
      wrap_at[s] = 0;
      wrap_cnt[s] = 0;
      chg_cnt[s] = 0;
    end
    repeat (5) @(negedge CLK);
    reset = 1'b0;

    for (int k = 0; k < 6; k++) begin
      v = $urandom;
      if (k == 2 || k == 3) begin
        v = v & 32'h0000_ffff;
      end
      apb_write(addrs[k], v);
      if (k == 2 || k == 3) begin
        m_cycle[k-2] = v[15:0];
      end
      apb_read(addrs[k], rd, err);
      check_word("register read back", v, rd);
      check_word("mapped pslverr", 32'd0, {31'd0, err});
    end
    v = {22'd0, 8'($urandom), 1'($urandom), 1'b0};
    apb_write(reg_ctrl, v);
    apb_read(reg_ctrl, rd, err);
    check_word("ctrl read back", v, rd);
    apb_read(16'h0030, rd, err);
    check_word("unmapped pslverr", 32'd1, {31'd0, err});

    for (int s = 0; s < 2; s++) begin
      for (int i = 0; i < 64; i++) begin
        mem_m[s][i] = $urandom;
        apb_write(pat_base + 16'(4 * (s * 64 + i)), mem_m[s][i]);
      end
      v = 2 + $urandom % 14;
      apb_write(s == 0 ? reg_cycle0 : reg_cycle1, v);
      m_cycle[s] = v[15:0];
    end

    apb_write(reg_rep1, rep_infinite);
    write_ctrl(1'b1, tm_sync_idx);
    check_segment("before immediate switch", 1'b0, segment);
    @(negedge CLK);
    check_segment("immediate switch", 1'b1, segment);
    check_stop("immediate switch stop", 1'b0, stop);
    m_seg = 1'b1;
    repeat (150) begin
      @(negedge CLK);
      check_stop("drive_valid while playing", 1'b1, drive_valid);
      check_segment("steady segment", m_seg, segment);
      check_word("drive word", mem_m[m_seg][p1[m_seg][5:0]], drive);
    end

    r = int'($urandom % 4);
    apb_write(reg_rep0, r);
    write_ctrl(1'b0, tm_sync_idx);
    base = wrap_cnt[0];
    wait_segment(1'b0, 2000);
    check_word("sync switch delay", 32'd1, cyc - wrap_at[0]);
    check_word("sync switch wrap", base + 1, wrap_cnt[0]);
    base = wrap_cnt[0];
    wait_stop(4000);
    check_word("sync stop delay", 32'd1, cyc - wrap_at[0]);
    check_word("sync stop wraps", base + r + 1, wrap_cnt[0]);
    @(negedge CLK);
    check_stop("drive_valid after stop", 1'b0, drive_valid);

    r = int'($urandom % 4);
    sel = 2'($urandom);
    apb_write(reg_rep1, r);
    apb_write(reg_value_lo, {30'd0, sel});
    apb_write(reg_value_hi, 32'd0);
    gpio_in = 4'($urandom) & ~(4'b0001 << sel); // selected line low.
    write_ctrl(1'b1, tm_gpio);
    @(negedge CLK);
    check_stop("gpio wait stop", 1'b0, stop);
    hold_segment(1, 3, 1'b0);
    gpio_in[sel] = 1'b1;
    wait_segment(1'b1, 500);
    base = chg_cnt[1];
    wait_stop(4000);
    check_word("gpio stop changes", (m_cycle[1] + 1) * (r + 1), chg_cnt[1] - base);

    r = int'($urandom % 4);
    target = 64'd1020 + 64'($urandom % 40);
    sys_time = 64'd1000;
    apb_write(reg_rep0, r);
    apb_write(reg_value_lo, target[31:0]);
    apb_write(reg_value_hi, target[63:32]);
    write_ctrl(1'b0, tm_sys_time);
    while (sys_time < target) begin
      @(negedge CLK);
      check_segment("before target time", 1'b1, segment);
      sys_time = sys_time + 64'd1;
    end
    @(negedge CLK);
    check_segment("compare latency", 1'b1, segment);
    base = chg_cnt[0];
    @(negedge CLK);
    check_segment("sys time switch", 1'b0, segment);
    wait_stop(4000);
    check_word("sys time stop changes", (m_cycle[0] + 1) * (r + 1), chg_cnt[0] - base);

    write_ctrl(1'b0, tm_ext);
    @(negedge CLK);
    check_stop("ext stop", 1'b0, stop);
    m_seg = 1'b0;
    repeat (4) begin
      wait_segment(~m_seg, 1000);
      check_word("ext toggle delay", 32'd1, cyc - wrap_at[m_seg]);
      m_seg = ~m_seg;
    end

    $display("STATUS: PASS");
    $finish;
  end

endmodule

/* verilog.f */
hdl/stm_pkg.sv
hdl/stm_apb_regs.sv
hdl/stm_sync_timer.sv
hdl/stm_swapchain.sv
hdl/stm_pattern_reader.sv
hdl/stm_top.sv
bench/stm_tb_sva.sv
bench/stm_tb.sv

/* Makefile */
.PHONY: all run clean

all: obj_dir/Vstm_tb

obj_dir/Vstm_tb: verilog.f $(wildcard hdl/*.sv) $(wildcard bench/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module stm_tb -f verilog.f

run: obj_dir/Vstm_tb
	./obj_dir/Vstm_tb

clean:
	rm -rf obj_dir
